// ==== Makefile ====
# Verilator flow for the cartridge loader testbench

LOG := sim.log

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --assert --top-module nes_cart_tb -f all.f

sim:
	verilator --binary -j 0 --timing --assert -Wno-fatal --top-module nes_cart_tb \
		-f all.f -o nes_cart_sim
	./obj_dir/nes_cart_sim > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "ERRORS FOUND" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all lint sim clean

// ==== all.f ====
verilog/nes_cart_pkg.sv
verilog/ines_header_parser.sv
verilog/rom_loader.sv
verilog/pad_mapper.sv
verilog/controller_port.sv
verilog/nes_cart_top.sv
verification/nes_cart_properties.sv
verification/nes_cart_tb.sv

// ==== verification/nes_cart_properties.sv ====
// Loader handshake properties
// Bound to the ROM loader, checks the memory handshake and status flags

`timescale 1ns/1ps

module nes_cart_properties (
	input logic                     clk,
	input logic                     reset_nes,
	input logic                     in_wait,
	input logic                     mem_valid,
	input logic                     mem_ready,
	input nes_cart_pkg::mem_write_t mem_req,
	input logic                     busy,
	input logic                     done,
	input logic                     error
);

	// Stalled write keeps its payload
	a_req_stable: assert property (@(posedge clk) disable iff (reset_nes)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
		else $error("memory request changed while stalled");

	// Rejected image never starts a load
	a_error_done: assert property (@(posedge clk) disable iff (reset_nes)
		error |-> done && !busy && !mem_valid)
		else $error("error high without done, or with a load in progress");

	a_busy_done: assert property (@(posedge clk) disable iff (reset_nes)
		!(busy && done))
		else $error("busy and done high together");

	// Byte side only waits on an open, unacknowledged write
	a_wait_valid: assert property (@(posedge clk) disable iff (reset_nes)
		in_wait |-> mem_valid && !$past(mem_valid && mem_ready))
		else $error("in_wait high without a pending write");

endmodule

bind rom_loader nes_cart_properties i_props (
	.clk       (clk),
	.reset_nes (reset_nes),
	.in_wait   (in_wait),
	.mem_valid (mem_valid),
	.mem_ready (mem_ready),
	.mem_req   (mem_req),
	.busy      (busy),
	.done      (done),
	.error     (error)
);

// ==== verification/nes_cart_tb.sv ====
// Cartridge loader and controller port testbench
// Streams random ROM images, checks writes and flags against a model,
// then reads both serial pads back bit by bit

`timescale 1ns/1ps

module nes_cart_tb;

	localparam int CLK_PERIOD = 4;
	localparam int ROM_MAX    = 16 + 2 * nes_cart_pkg::PRG_PAGE_BYTES;
	// Every ROM byte streamed by all tests, plus room for the pad tests
	localparam int TOTAL_BYTES     = 2 * 24592 + 4 * ROM_MAX + 2 * 24 + 1000;
	localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 20 + 5000;

	logic                        clk = 1'b0;
	logic                        reset_nes;
	logic                        in_valid;
	nes_cart_pkg::byte_t         in_data;
	logic                        invert_mirroring;
	logic                        mem_ready;
	logic [7:0]                  host_pad [4];
	nes_cart_pkg::pad_buttons_t  pad_a;
	nes_cart_pkg::pad_buttons_t  pad_b;
	nes_cart_pkg::pad_buttons_t  pad_c;
	nes_cart_pkg::pad_buttons_t  pad_d;
	logic                        joy_swap;
	logic                        multitap_en;
	logic                        joypad_strobe;
	logic [1:0]                  joypad_clock;
	logic                        in_wait;
	logic                        mem_valid;
	nes_cart_pkg::mem_write_t    mem_req;
	nes_cart_pkg::mapper_flags_t mapper_flags;
	logic                        busy;
	logic                        done;
	logic                        error;
	logic [1:0]                  joypad_data;

	integer     seed;
	logic [7:0] rom [ROM_MAX];   // Header at 0, then PRG, then CHR
	int         rom_len;
	int         wr_count;
	logic       saw_write;
	logic       saw_busy;
	int         tests;
	int         failed;
	int         checks;
	int         errors;

	assign pad_a = host_pad[0];
	assign pad_b = host_pad[1];
	assign pad_c = host_pad[2];
	assign pad_d = host_pad[3];

	nes_cart_top i_nes_cart_top (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [7:0] rand_byte();
		int r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("FAILURE at %0t ns: %s", $time, what);
		errors++;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("test %s: passed", name);
		end else begin
			failed++;
			$display("test %s: failed with %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset_nes = 1'b1;
		repeat (4) @(negedge clk);
		reset_nes = 1'b0;
	endtask

	////////////////////
	// Reference model
	////////////////////

	// Smallest k with pages <= 2^k, capped at 7
	function automatic logic [2:0] page_code(input logic [7:0] pages);
		int code;
		code = 0;
		while (code < 7 && (1 << code) < pages)
			code++;
		return code[2:0];
	endfunction

	function automatic logic [31:0] expected_flags();
		logic [31:0] f;
		logic        nes2;
		logic        dirty;
		nes2  = (rom[7][3:2] == 2'b10);
		dirty = 1'b0;
		for (int i = 9; i < 16; i++) begin
			if (rom[i] != 8'h00)
				dirty = 1'b1;
		end
		f        = '0;
		f[7:0]   = {(dirty && !nes2) ? 4'h0 : rom[7][7:4], rom[6][7:4]};
		f[10:8]  = page_code(rom[4]);
		f[13:11] = page_code(rom[5]);
		f[14]    = rom[6][0] ^ invert_mirroring;
		f[15]    = (rom[5] == 8'h00);
		f[16]    = rom[6][3];
		f[24:17] = nes2 ? rom[8] : 8'h00;
		f[25]    = rom[6][1];
		return f;
	endfunction

	// Host order to shift order, A leaves first
	function automatic logic [7:0] nes_byte(input logic [7:0] h);
		return {h[0], h[1], h[2], h[3], h[7], h[6], h[5], h[4]};
	endfunction

	function automatic logic [23:0] expected_frame(input int port);
		logic [7:0] main_pad;
		logic [7:0] tap;
		logic [7:0] sig;
		main_pad = ((port == 0) ^ joy_swap) ? host_pad[0] : host_pad[1];
		tap      = (port == 0) ? host_pad[2] : host_pad[3];
		sig      = (port == 0) ? nes_cart_pkg::TAP_SIG_PORT0 : nes_cart_pkg::TAP_SIG_PORT1;
		if (multitap_en)
			return {sig, nes_byte(tap), nes_byte(main_pad)};
		return {16'hFFFF, nes_byte(main_pad)};
	endfunction

	////////////////////
	// Stimulus
	////////////////////

	task automatic make_rom(input logic [7:0] prg_pages, input logic [7:0] chr_pages,
	                        input logic bad_sig, input logic trainer);
		logic [7:0] r;
		rom[0] = 8'h4E;
		rom[1] = 8'h45;
		rom[2] = 8'h53;
		rom[3] = bad_sig ? 8'h1B : 8'h1A;
		rom[4] = prg_pages;
		rom[5] = chr_pages;
		for (int i = 6; i < 16; i++)
			rom[i] = rand_byte();
		rom[6][2] = trainer;
		r = rand_byte();
		if (r[0]) begin
			for (int i = 9; i < 16; i++)
				rom[i] = 8'h00;   // Clean iNES 1.0 tail
		end
		rom_len = 16 + int'(prg_pages) * nes_cart_pkg::PRG_PAGE_BYTES +
		          int'(chr_pages) * nes_cart_pkg::CHR_PAGE_BYTES;
		for (int i = 16; i < rom_len; i++)
			rom[i] = rand_byte();
	endtask

	// Streams rom[0 .. rom_len-1] and checks every accepted write
	task automatic run_load(input logic gaps, input logic stalls);
		int                       ptr;
		int                       cycles;
		int                       limit;
		int                       prg_len;
		logic [7:0]               r;
		nes_cart_pkg::cart_addr_t exp_addr;
		ptr       = 0;
		cycles    = 0;
		limit     = rom_len * 20 + 100;
		prg_len   = int'(rom[4]) * nes_cart_pkg::PRG_PAGE_BYTES;
		wr_count  = 0;
		saw_write = 1'b0;
		saw_busy  = 1'b0;
		while ((!done || ptr < rom_len) && cycles < limit) begin
			@(negedge clk);
			cycles++;
			r = rand_byte();
			mem_ready = !stalls || (r[1:0] != 2'b00);   // About one stall in four
			if (mem_valid)
				saw_write = 1'b1;
			if (busy)
				saw_busy = 1'b1;
			if (mem_valid && mem_ready) begin
				if (16 + wr_count >= rom_len) begin
					report_failure("memory write beyond the end of the ROM image");
				end else begin
					if (wr_count < prg_len)
						exp_addr = nes_cart_pkg::cart_addr_t'(wr_count);
					else
						exp_addr = nes_cart_pkg::CHR_BASE +
						           nes_cart_pkg::cart_addr_t'(wr_count - prg_len);
					check_value("mem_req.addr", mem_req.addr, exp_addr);
					check_value("mem_req.data", mem_req.data, rom[16 + wr_count]);
				end
				wr_count++;
			end
			r = rand_byte();
			in_valid = (ptr < rom_len) && (!gaps || (r[1:0] != 2'b00));
			if (ptr < rom_len)
				in_data = rom[ptr];
			if (in_valid && !in_wait)
				ptr++;                                   // Taken at the next edge
		end
		in_valid  = 1'b0;
		mem_ready = 1'b1;
		assert (cycles < limit) else report_failure("load did not reach done in time");
	endtask

	// Strobe, then 28 reads with a falling port clock between them
	task automatic run_pads(input logic tap, input logic swap);
		logic [23:0] frame [2];
		logic        exp;
		@(negedge clk);
		for (int i = 0; i < 4; i++)
			host_pad[i] = rand_byte();
		multitap_en   = tap;
		joy_swap      = swap;
		joypad_strobe = 1'b1;
		@(negedge clk);
		joypad_strobe = 1'b0;
		frame[0] = expected_frame(0);
		frame[1] = expected_frame(1);
		for (int idx = 0; idx < 28; idx++) begin
			for (int p = 0; p < 2; p++) begin
				exp = (idx < 24) ? frame[p][idx] : 1'b0;
				check_value(p == 0 ? "joypad_data[0]" : "joypad_data[1]",
				            32'(joypad_data[p]), 32'(exp));
			end
			joypad_clock = 2'b11;
			@(negedge clk);
			joypad_clock = 2'b00;
			@(negedge clk);
		end
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		int         e0;
		logic [7:0] r;
		seed             = 32'hd168_98d7;
		reset_nes        = 1'b1;
		in_valid         = 1'b0;
		in_data          = 8'h00;
		invert_mirroring = 1'b0;
		mem_ready        = 1'b1;
		for (int i = 0; i < 4; i++)
			host_pad[i] = 8'h00;
		joy_swap      = 1'b0;
		multitap_en   = 1'b0;
		joypad_strobe = 1'b0;
		joypad_clock  = 2'b00;
		tests  = 0;
		failed = 0;
		checks = 0;
		errors = 0;

		e0 = errors;
		make_rom(8'd1, 8'd1, 1'b0, 1'b0);
		apply_reset();
		run_load(1'b0, 1'b0);
		check_value("write count", wr_count, 24576);
		assert (saw_busy) else report_failure("busy never went high during the load");
		check_value("busy", 32'(busy), 0);
		check_value("done", 32'(done), 1);
		check_value("error", 32'(error), 0);
		check_value("mapper_flags", mapper_flags, expected_flags());
		finish_test("full load", e0);

		// Same image again under back-pressure
		e0 = errors;
		apply_reset();
		run_load(1'b1, 1'b1);
		check_value("write count", wr_count, 24576);
		assert (saw_busy) else report_failure("busy never went high during the load");
		check_value("busy", 32'(busy), 0);
		check_value("done", 32'(done), 1);
		check_value("error", 32'(error), 0);
		finish_test("stalls and gaps", e0);

		for (int n = 0; n < 4; n++) begin
			e0 = errors;
			r = rand_byte();
			make_rom(r % 8'd3, 8'd0, 1'b0, 1'b0);
			invert_mirroring = r[7];
			apply_reset();
			run_load(1'b0, 1'b0);
			check_value("write count", wr_count, int'(rom[4]) * nes_cart_pkg::PRG_PAGE_BYTES);
			check_value("done", 32'(done), 1);
			check_value("mapper_flags", mapper_flags, expected_flags());
			finish_test("CHR RAM flags", e0);
		end
		invert_mirroring = 1'b0;

		for (int n = 0; n < 2; n++) begin
			e0 = errors;
			make_rom(8'd1, 8'd0, n == 0, n == 1);
			rom_len = 24;                      // Header plus bytes to be discarded
			apply_reset();
			run_load(1'b0, 1'b0);
			assert (!saw_write) else report_failure("memory write issued for a rejected header");
			check_value("done", 32'(done), 1);
			check_value("error", 32'(error), 1);
			check_value("busy", 32'(busy), 0);
			finish_test(n == 0 ? "bad signature" : "trainer rejected", e0);
		end

		for (int n = 0; n < 4; n++) begin
			e0 = errors;
			run_pads(n[1], n[0]);
			finish_test(n[1] ? "pads with multitap" : "pads without multitap", e0);
		end

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== verilog/controller_port.sv ====
// Serial controller port
// Loads a 24-bit frame on strobe, shifts one bit per falling
// edge of the port clock

`timescale 1ns/1ps

module controller_port (
	input  logic                     clk,
	input  logic                     reset_nes,
	input  logic                     strobe,
	input  logic                     shift_clk,
	input  nes_cart_pkg::pad_frame_t frame,
	output logic                     data
);

	nes_cart_pkg::pad_frame_t bits;
	logic                     shift_clk_d;   // Port clock one cycle back
	logic                     shift_fall;

	assign shift_fall = shift_clk_d && !shift_clk;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			bits        <= '0;
			shift_clk_d <= 1'b0;
		end else begin
			shift_clk_d <= shift_clk;
			if (strobe)
				bits <= frame;             // Strobe beats a shift
			else if (shift_fall)
				bits <= nes_cart_pkg::pad_frame_t'({1'b0, bits[23:1]});
		end
	end

	assign data = bits[0];

endmodule

// ==== verilog/ines_header_parser.sv ====
// iNES header parser
// Collects the 16 header bytes, checks the signature and
// derives the mapper flag word and the PRG/CHR byte counts

`timescale 1ns/1ps

module ines_header_parser (
	input  logic                        clk,
	input  logic                        reset_nes,
	input  logic                        take,
	input  nes_cart_pkg::byte_t         data,
	input  logic                        invert_mirroring,
	output logic                        header_done,
	output logic                        header_ok,
	output nes_cart_pkg::cart_addr_t    prg_bytes,
	output nes_cart_pkg::cart_addr_t    chr_bytes,
	output nes_cart_pkg::mapper_flags_t flags
);

	localparam int CTR_W = $clog2(nes_cart_pkg::HEADER_BYTES);

	nes_cart_pkg::byte_t hdr [nes_cart_pkg::HEADER_BYTES];
	logic [CTR_W-1:0]    ctr;
	logic                is_nes20;
	logic                is_dirty;

	// Page count to size code, 0 or 1 page gives 0
	function automatic logic [2:0] size_code(input nes_cart_pkg::byte_t pages);
		logic [2:0] code;
		code = 3'd7;
		for (int k = 6; k >= 0; k--) begin
			if (pages <= (9'd1 << k))
				code = 3'(k);
		end
		return code;
	endfunction

	////////////////////
	// Byte capture
	////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			ctr         <= '0;
			header_done <= 1'b0;
		end else if (take && !header_done) begin
			ctr <= ctr + 1'b1;
			if (ctr == CTR_W'(nes_cart_pkg::HEADER_BYTES - 1))
				header_done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take && !header_done)
			hdr[ctr] <= data;
	end

	////////////////////
	// Verdict and flags
	////////////////////

	// "NES" + EOF, trainers are not supported
	assign header_ok = (hdr[0] == 8'h4E) && (hdr[1] == 8'h45) &&
	                   (hdr[2] == 8'h53) && (hdr[3] == 8'h1A) && !hdr[6][2];

	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	// Old dumps often carry junk in bytes 9 to 15
	always_comb begin
		is_dirty = 1'b0;
		for (int i = 9; i < nes_cart_pkg::HEADER_BYTES; i++) begin
			if (hdr[i] != 8'h00)
				is_dirty = 1'b1;
		end
		is_dirty = is_dirty && !is_nes20;
	end

	always_comb begin
		flags             = '0;
		flags.mapper      = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
		flags.prg_size    = size_code(hdr[4]);
		flags.chr_size    = size_code(hdr[5]);
		flags.mirroring   = hdr[6][0] ^ invert_mirroring;
		flags.chr_ram     = (hdr[5] == 8'h00);
		flags.four_screen = hdr[6][3];
		flags.nes2_byte   = is_nes20 ? hdr[8] : 8'h00;
		flags.has_saves   = hdr[6][1];
	end

	assign prg_bytes = nes_cart_pkg::cart_addr_t'(hdr[4]) *
	                   nes_cart_pkg::cart_addr_t'(nes_cart_pkg::PRG_PAGE_BYTES);
	assign chr_bytes = nes_cart_pkg::cart_addr_t'(hdr[5]) *
	                   nes_cart_pkg::cart_addr_t'(nes_cart_pkg::CHR_PAGE_BYTES);

endmodule

// ==== verilog/nes_cart_pkg.sv ====
// Cartridge loader and controller port definitions
// Shared types, loader states and iNES format constants

package nes_cart_pkg;

	////////////////////
	// Memory side
	////////////////////

	typedef logic [21:0] cart_addr_t;   // 4MB cartridge space
	typedef logic [7:0]  byte_t;

	// One write into cartridge memory
	typedef struct packed {
		cart_addr_t addr;
		byte_t      data;
	} mem_write_t;

	// Mapper flag word as seen by the console core
	typedef struct packed {
		logic [5:0] reserved;
		logic       has_saves;     // Battery backed RAM
		byte_t      nes2_byte;     // Byte 8 of a NES 2.0 header
		logic       four_screen;
		logic       chr_ram;       // No CHR ROM pages
		logic       mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		byte_t      mapper;
	} mapper_flags_t;

	typedef enum logic [2:0] {
		S_HEADER,
		S_PRG,
		S_CHR,
		S_ERROR,
		S_DONE
	} loader_state_e;

	////////////////////
	// Pad side
	////////////////////

	// Host button order, right in bit 0
	typedef struct packed {
		logic start;
		logic select;
		logic b;
		logic a;
		logic up;
		logic down;
		logic left;
		logic right;
	} pad_buttons_t;

	// Serial frame, shifted out from bit 0
	typedef struct packed {
		byte_t signature;     // Multitap id or all ones
		byte_t tap_buttons;   // Pad C or D
		byte_t buttons;
	} pad_frame_t;

	localparam int         HEADER_BYTES   = 16;
	localparam int         PRG_PAGE_BYTES = 16384;
	localparam int         CHR_PAGE_BYTES = 8192;
	localparam cart_addr_t CHR_BASE       = 22'h200000;
	localparam int         NUM_PORTS      = 2;
	localparam byte_t      TAP_SIG_PORT0  = 8'h08;
	localparam byte_t      TAP_SIG_PORT1  = 8'h04;

endpackage

// ==== verilog/nes_cart_top.sv ====
// Cartridge loader and controller ports
// Joins the ROM loader with the pad mapper and the serial ports

`timescale 1ns/1ps

module nes_cart_top (
	input  logic                                clk,
	input  logic                                reset_nes,
	input  logic                                in_valid,
	input  nes_cart_pkg::byte_t                 in_data,
	input  logic                                invert_mirroring,
	input  logic                                mem_ready,
	input  nes_cart_pkg::pad_buttons_t          pad_a,
	input  nes_cart_pkg::pad_buttons_t          pad_b,
	input  nes_cart_pkg::pad_buttons_t          pad_c,
	input  nes_cart_pkg::pad_buttons_t          pad_d,
	input  logic                                joy_swap,
	input  logic                                multitap_en,
	input  logic                                joypad_strobe,
	input  logic [nes_cart_pkg::NUM_PORTS-1:0]  joypad_clock,
	output logic                                in_wait,
	output logic                                mem_valid,
	output nes_cart_pkg::mem_write_t            mem_req,
	output nes_cart_pkg::mapper_flags_t         mapper_flags,
	output logic                                busy,
	output logic                                done,
	output logic                                error,
	output logic [nes_cart_pkg::NUM_PORTS-1:0]  joypad_data
);

	nes_cart_pkg::pad_frame_t frames [nes_cart_pkg::NUM_PORTS];

	rom_loader i_loader (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.in_valid         (in_valid),
		.in_data          (in_data),
		.invert_mirroring (invert_mirroring),
		.mem_ready        (mem_ready),
		.in_wait          (in_wait),
		.mem_valid        (mem_valid),
		.mem_req          (mem_req),
		.flags            (mapper_flags),
		.busy             (busy),
		.done             (done),
		.error            (error)
	);

	pad_mapper i_pads (
		.pad_a       (pad_a),
		.pad_b       (pad_b),
		.pad_c       (pad_c),
		.pad_d       (pad_d),
		.joy_swap    (joy_swap),
		.multitap_en (multitap_en),
		.frames      (frames)
	);

	// One serial port per controller socket
	for (genvar p = 0; p < nes_cart_pkg::NUM_PORTS; p++) begin : g_port
		controller_port i_port (
			.clk       (clk),
			.reset_nes (reset_nes),
			.strobe    (joypad_strobe),
			.shift_clk (joypad_clock[p]),
			.frame     (frames[p]),
			.data      (joypad_data[p])
		);
	end

endmodule

// ==== verilog/pad_mapper.sv ====
// Pad mapper
// Reorders host buttons into NES shift order and builds the
// serial frame of each port, with optional multitap pads

`timescale 1ns/1ps

module pad_mapper (
	input  nes_cart_pkg::pad_buttons_t pad_a,
	input  nes_cart_pkg::pad_buttons_t pad_b,
	input  nes_cart_pkg::pad_buttons_t pad_c,
	input  nes_cart_pkg::pad_buttons_t pad_d,
	input  logic                       joy_swap,
	input  logic                       multitap_en,
	output nes_cart_pkg::pad_frame_t   frames [nes_cart_pkg::NUM_PORTS]
);

	nes_cart_pkg::byte_t main_pad [nes_cart_pkg::NUM_PORTS];
	nes_cart_pkg::byte_t tap_pad  [nes_cart_pkg::NUM_PORTS];

	// A goes out first, right last
	function automatic nes_cart_pkg::byte_t nes_order(input nes_cart_pkg::pad_buttons_t pad);
		return {pad.right, pad.left, pad.down, pad.up, pad.start, pad.select, pad.b, pad.a};
	endfunction

	assign main_pad[0] = nes_order(joy_swap ? pad_b : pad_a);
	assign main_pad[1] = nes_order(joy_swap ? pad_a : pad_b);
	assign tap_pad[0]  = nes_order(pad_c);
	assign tap_pad[1]  = nes_order(pad_d);

	always_comb begin
		for (int p = 0; p < nes_cart_pkg::NUM_PORTS; p++) begin
			frames[p].buttons     = main_pad[p];
			// Without multitap the upper 16 bits read back as ones
			frames[p].tap_buttons = multitap_en ? tap_pad[p] : 8'hFF;
			frames[p].signature   = !multitap_en ? 8'hFF :
			                        (p == 0) ? nes_cart_pkg::TAP_SIG_PORT0 :
			                                   nes_cart_pkg::TAP_SIG_PORT1;
		end
	end

endmodule

// ==== verilog/rom_loader.sv ====
// ROM loader
// Takes a ROM image byte by byte, hands the header to the parser
// and writes PRG and CHR data into cartridge memory

`timescale 1ns/1ps

module rom_loader (
	input  logic                        clk,
	input  logic                        reset_nes,
	input  logic                        in_valid,
	input  nes_cart_pkg::byte_t         in_data,
	input  logic                        invert_mirroring,
	input  logic                        mem_ready,
	output logic                        in_wait,
	output logic                        mem_valid,
	output nes_cart_pkg::mem_write_t    mem_req,
	output nes_cart_pkg::mapper_flags_t flags,
	output logic                        busy,
	output logic                        done,
	output logic                        error
);

	nes_cart_pkg::loader_state_e state;
	nes_cart_pkg::loader_state_e seg_state;
	nes_cart_pkg::cart_addr_t    left;        // Bytes still due in this segment
	nes_cart_pkg::cart_addr_t    seg_left;
	nes_cart_pkg::cart_addr_t    addr;
	nes_cart_pkg::cart_addr_t    seg_addr;
	nes_cart_pkg::cart_addr_t    prg_bytes;
	nes_cart_pkg::cart_addr_t    chr_bytes;
	logic                        header_done;
	logic                        header_ok;
	logic                        take;
	logic                        data_take;
	logic                        write_busy;  // Write still open after this edge

	assign in_wait    = mem_valid;
	assign take       = in_valid && !in_wait;
	assign write_busy = mem_valid && !mem_ready;

	ines_header_parser i_header (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.take             (take && (state == nes_cart_pkg::S_HEADER)),
		.data             (in_data),
		.invert_mirroring (invert_mirroring),
		.header_done      (header_done),
		.header_ok        (header_ok),
		.prg_bytes        (prg_bytes),
		.chr_bytes        (chr_bytes),
		.flags            (flags)
	);

	////////////////////
	// Segment select
	////////////////////

	// Resolve pending transitions first, so a byte taken this cycle
	// already lands in the right segment
	always_comb begin
		seg_state = state;
		seg_left  = left;
		seg_addr  = addr;
		if (state == nes_cart_pkg::S_HEADER && header_done) begin
			if (header_ok) begin
				seg_state = nes_cart_pkg::S_PRG;
				seg_left  = prg_bytes;
				seg_addr  = '0;
			end else begin
				seg_state = nes_cart_pkg::S_ERROR;
			end
		end
		if (seg_state == nes_cart_pkg::S_PRG && seg_left == '0 && !write_busy) begin
			seg_state = nes_cart_pkg::S_CHR;
			seg_left  = chr_bytes;
			seg_addr  = nes_cart_pkg::CHR_BASE;
		end
		if (seg_state == nes_cart_pkg::S_CHR && seg_left == '0 && !write_busy)
			seg_state = nes_cart_pkg::S_DONE;
	end

	assign data_take = take &&
	                   (seg_state == nes_cart_pkg::S_PRG || seg_state == nes_cart_pkg::S_CHR);

	////////////////////
	// State and status
	////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state     <= nes_cart_pkg::S_HEADER;
			left      <= '0;
			addr      <= '0;
			mem_valid <= 1'b0;
			busy      <= 1'b0;
			done      <= 1'b0;
			error     <= 1'b0;
		end else begin
			state <= seg_state;
			left  <= seg_left;
			addr  <= seg_addr;
			if (data_take) begin
				left      <= seg_left - 1'b1;
				addr      <= seg_addr + 1'b1;
				mem_valid <= 1'b1;
			end else if (mem_ready) begin
				mem_valid <= 1'b0;           // Write accepted
			end
			if (seg_state == nes_cart_pkg::S_PRG || seg_state == nes_cart_pkg::S_CHR)
				busy <= 1'b1;
			case (state)
				nes_cart_pkg::S_DONE: begin
					done <= 1'b1;
					busy <= 1'b0;
				end
				nes_cart_pkg::S_ERROR: begin
					done  <= 1'b1;
					error <= 1'b1;
				end
				default: ;
			endcase
		end
	end

	// Payload held until mem_ready
	always_ff @(posedge clk) begin
		if (data_take) begin
			mem_req.addr <= seg_addr;
			mem_req.data <= in_data;
		end
	end

endmodule
